// ==== design/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Fetch front end widths, fixed for a 32-bit core

// Byte address, also the program counter
`define FETCH_ADDR_W  32

// One memory word as fetched
`define FETCH_INSTR_W 32

// One compressed parcel
`define FETCH_HALF_W  16

`endif

// ==== design/fetch_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

  // Byte address, one word wide
  typedef logic [`FETCH_ADDR_W-1:0]  addr_t;

  // Instruction as delivered, compressed ones zero-extended
  typedef logic [`FETCH_INSTR_W-1:0] instr_t;

  // Single 16-bit parcel
  typedef logic [`FETCH_HALF_W-1:0]  half_t;

  // Which part of the fetched word goes out
  typedef enum logic [1:0] {
    FMT_FULL,    // Full instruction, word aligned
    FMT_C_LOW,   // Compressed, low half of the word
    FMT_C_HIGH   // Compressed, high half of the word
  } instr_fmt_e;

endpackage

`default_nettype wire

// ==== design/instr_mem_if.sv ====
`default_nettype none

// Instruction memory port, plain req/gnt with a separate rvalid strobe
interface instr_mem_if;
  import fetch_pkg::*;

  logic   req;     // Request strobe
  logic   gnt;     // Request accepted this cycle
  addr_t  addr;    // Always a word address
  instr_t rdata;   // Read word, qualified by rvalid
  logic   rvalid;  // One pulse per granted request, in order

  // Fetch buffer side
  modport fetcher (
    output req,
    output addr,
    input  gnt,
    input  rdata,
    input  rvalid
  );

  // Memory side
  modport memory (
    input  req,
    input  addr,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface

`default_nettype wire

// ==== design/fetch_if.sv ====
`default_nettype none

// Buffer to fetch/decode register, valid/ready levels
interface fetch_if;
  import fetch_pkg::*;

  logic   valid;  // Instruction on offer
  logic   ready;  // Consumer can take it
  instr_t instr;  // Zero-extended when compressed
  addr_t  pc;     // Byte address of the instruction

  modport producer (
    output valid,
    output instr,
    output pc,
    input  ready
  );

  modport consumer (
    input  valid,
    input  instr,
    input  pc,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/prefetch_aligned.sv ====
`default_nettype none

`include "fetch_cfg.svh"

module prefetch_aligned (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,          // Core wants instructions
  input  logic             branch_i,       // One-cycle redirect pulse
  input  fetch_pkg::addr_t branch_addr_i,  // Redirect target that may be a halfword address
  instr_mem_if.fetcher     mem,
  fetch_if.producer        out,
  output logic             busy_o
);
  import fetch_pkg::*;

  // Steps of the memory handshake
  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID, WAIT_ABORTED} state_e;

  state_e     state_q, state_n;
  addr_t      fetch_addr_q, fetch_addr_n;    // Pc of the instruction being worked on
  instr_t     fetch_rdata_q;                 // Holding register for one word
  logic       fetch_valid_q, fetch_valid_n;  // Holding register is loaded

  addr_t      addr_pc_next;  // Output of the one pc adder
  addr_t      req_addr;      // Address behind the current request
  instr_t     instr_mux;     // Word from memory or from the holding register
  half_t      half_sel;
  instr_fmt_e instr_fmt;
  logic       launch;        // Put a request on the bus this cycle
  logic       outstanding;   // Granted access still waiting for rvalid
  logic       half_in_regs;  // Pending high half that needs no memory access

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign instr_mux    = fetch_valid_q ? fetch_rdata_q : mem.rdata;
  assign half_in_regs = fetch_valid_q && fetch_addr_q[1];
  assign outstanding  = (state_q == WAIT_RVALID) && !fetch_valid_q;

  // Format from the pc alignment and the opcode's low bits
  always_comb begin
    if (fetch_addr_q[1]) begin
      instr_fmt = FMT_C_HIGH;  // Only compressed allowed at halfword addresses
    end else if (instr_mux[1:0] != 2'b11) begin
      instr_fmt = FMT_C_LOW;
    end else begin
      instr_fmt = FMT_FULL;
    end
  end

  // Single adder steps 4 for a full instruction and 2 for a compressed one
  assign addr_pc_next = fetch_addr_q + ((instr_fmt == FMT_FULL) ? addr_t'(4) : addr_t'(2));

  assign half_sel  = fetch_addr_q[1] ? instr_mux[`FETCH_INSTR_W-1:`FETCH_HALF_W]
                                     : instr_mux[`FETCH_HALF_W-1:0];
  assign out.instr = (instr_fmt == FMT_FULL) ? instr_mux
                   : {{(`FETCH_INSTR_W-`FETCH_HALF_W){1'b0}}, half_sel};  // Upper half zeroed
  assign out.pc    = fetch_addr_q;

  assign mem.addr = {req_addr[`FETCH_ADDR_W-1:2], 2'b00};  // Memory only sees words
  assign busy_o   = (state_q != IDLE) || mem.req;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n       = state_q;
    fetch_addr_n  = fetch_addr_q;
    fetch_valid_n = fetch_valid_q;
    req_addr      = fetch_addr_q;
    launch        = 1'b0;
    out.valid     = 1'b0;
    mem.req       = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (branch_i) begin
          fetch_addr_n  = branch_addr_i;  // Drop any pending half
          fetch_valid_n = 1'b0;
          req_addr      = branch_addr_i;
          launch        = req_i;
        end else if (req_i && half_in_regs) begin
          out.valid = 1'b1;  // Second compressed half straight from the register
          if (out.ready) begin
            fetch_addr_n  = addr_pc_next;
            fetch_valid_n = 1'b0;
          end
        end else begin
          launch = req_i;
        end
      end

      WAIT_GNT: begin
        launch = 1'b1;  // Keep asking until granted
        if (branch_i) begin
          req_addr = branch_addr_i;  // Not accepted yet so only the target changes
        end
      end

      WAIT_RVALID: begin
        if (branch_i) begin
          fetch_addr_n  = branch_addr_i;
          fetch_valid_n = 1'b0;
          req_addr      = branch_addr_i;
          if (outstanding && !mem.rvalid) begin
            state_n = WAIT_ABORTED;  // Old response still on its way
          end else begin
            state_n = IDLE;
            launch  = req_i;
          end
        end else if (mem.rvalid || fetch_valid_q) begin
          out.valid     = 1'b1;
          fetch_valid_n = 1'b1;  // Park the word while decode stalls
          if (out.ready) begin
            fetch_addr_n = addr_pc_next;
            state_n      = IDLE;
            if (instr_fmt != FMT_C_LOW) begin
              fetch_valid_n = 1'b0;  // Word used up
              req_addr      = addr_pc_next;
              launch        = req_i;
            end
          end
        end
      end

      WAIT_ABORTED: begin
        if (branch_i) begin
          fetch_addr_n = branch_addr_i;  // Newest target wins
          req_addr     = branch_addr_i;
        end
        if (mem.rvalid) begin
          state_n = IDLE;  // Wrong-path word dropped here
          launch  = req_i;
        end
      end

      default: state_n = IDLE;
    endcase

    if (launch) begin
      mem.req       = 1'b1;
      fetch_addr_n  = req_addr;
      fetch_valid_n = 1'b0;
      state_n       = mem.gnt ? WAIT_RVALID : WAIT_GNT;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      fetch_addr_q  <= '0;
      fetch_valid_q <= 1'b0;
    end else begin
      state_q       <= state_n;
      fetch_addr_q  <= fetch_addr_n;
      fetch_valid_q <= fetch_valid_n;
    end
  end

  // Tracks memory until the word is parked
  always_ff @(posedge clk) begin
    if (!fetch_valid_q) begin
      fetch_rdata_q <= mem.rdata;
    end
  end

  // Ungranted request holds its address unless a branch retargets it
  assert property (@(posedge clk) disable iff (!rst_n)
    (mem.req && !mem.gnt) |=> (branch_i || (mem.req && $stable(mem.addr))));

  // A response in idle would belong to no request
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> !mem.rvalid);

endmodule

`default_nettype wire

// ==== design/if_id_stage.sv ====
`default_nettype none

module if_id_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              branch_i,        // Flush, wrong path behind us
  fetch_if.consumer         in,
  input  logic              id_ready_i,      // Decode takes the entry
  output logic              id_valid_o,
  output fetch_pkg::instr_t id_instr_o,
  output fetch_pkg::addr_t  id_pc_o,
  output logic              id_compressed_o  // Low bits not 11
);

  logic take;  // Transfer from the buffer this cycle

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Room when empty or draining, nothing accepted during a flush
  assign in.ready = !branch_i && (!id_valid_o || id_ready_i);
  assign take     = in.valid && in.ready;

  // Occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (branch_i) begin
      id_valid_o <= 1'b0;  // Wrong-path entry discarded
    end else if (take) begin
      id_valid_o <= 1'b1;  // Refill, also when decode drains this cycle
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (take) begin
      id_instr_o      <= in.instr;
      id_pc_o         <= in.pc;
      id_compressed_o <= (in.instr[1:0] != 2'b11);  // Marked once, at capture
    end
  end

  // Stalled entry stays put until decode takes it or a branch flushes it
  assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && !id_ready_i && !branch_i) |=>
      (id_valid_o && $stable(id_instr_o) && $stable(id_pc_o) &&
       $stable(id_compressed_o)));

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`default_nettype none

module fetch_top (
  input  logic              clk,
  input  logic              rst_n,

  // Core control
  input  logic              fetch_en_i,
  input  logic              branch_i,
  input  fetch_pkg::addr_t  branch_addr_i,

  // Decode side
  input  logic              id_ready_i,
  output logic              id_valid_o,
  output fetch_pkg::instr_t id_instr_o,
  output fetch_pkg::addr_t  id_pc_o,
  output logic              id_compressed_o,
  output logic              busy_o,

  // Instruction memory
  output logic              instr_req_o,
  input  logic              instr_gnt_i,
  output fetch_pkg::addr_t  instr_addr_o,
  input  fetch_pkg::instr_t instr_rdata_i,
  input  logic              instr_rvalid_i
);

  instr_mem_if mem_bus ();    // Buffer to memory pins
  fetch_if     fetch_bus ();  // Buffer to fetch/decode register

  // Memory pins
  assign instr_req_o    = mem_bus.req;
  assign instr_addr_o   = mem_bus.addr;
  assign mem_bus.gnt    = instr_gnt_i;
  assign mem_bus.rdata  = instr_rdata_i;
  assign mem_bus.rvalid = instr_rvalid_i;

  prefetch_aligned i_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem           (mem_bus.fetcher),
    .out           (fetch_bus.producer),
    .busy_o        (busy_o)
  );

  if_id_stage i_if_id (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .in              (fetch_bus.consumer),
    .id_ready_i      (id_ready_i),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o)
  );

endmodule

`default_nettype wire

// ==== verif/instr_mem_model.sv ====
`default_nettype none

// Instruction memory for the testbench, random grant delay, fixed one-cycle read
module instr_mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  fetch_pkg::addr_t  addr_i,
  output logic              gnt_o,
  output fetch_pkg::instr_t rdata_o,
  output logic              rvalid_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int WORDS = 256;  // 1 KB program image

  instr_t     image [WORDS];
  logic [1:0] gnt_wait;            // Cycles left before the next grant
  integer     seed = 62834;
  int         grant_count;         // Accepted requests since reset
  int         resp_count;          // rvalid pulses since reset

  // Parcel tagged by its halfword address, low bits 01 mark it compressed
  function automatic half_t half_word(int h);
    return {14'(h), 2'b01};
  endfunction

  // Words 0..31 all full, above that a full word every third slot, pairs between
  initial begin
    int w;
    for (w = 0; w < WORDS; w++) begin
      if (w >= 32 && (w % 3) != 0) begin
        image[w] = {half_word(2 * w + 1), half_word(2 * w)};
      end else begin
        image[w] = {30'(w), 2'b11};  // Full word, upper bits from the address
      end
    end
  end

  assign gnt_o = req_i && (gnt_wait == 2'd0);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait    <= 2'd0;
      rdata_o     <= '0;
      rvalid_o    <= 1'b0;
      grant_count <= 0;
      resp_count  <= 0;
    end else begin
      rvalid_o <= gnt_o;  // Response exactly one cycle after the grant
      if (rvalid_o) resp_count <= resp_count + 1;
      if (gnt_o) begin
        rdata_o     <= image[addr_i[9:2]];
        grant_count <= grant_count + 1;
        gnt_wait    <= 2'($random(seed));  // 0 to 3 cycles for the next one
      end else if (req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_fetch_top.sv ====
`default_nettype none

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int    CLK_PERIOD = 8;
  localparam int    N_FULL     = 20;      // Aligned stream deliveries
  localparam int    N_MIXED    = 40;
  localparam int    N_BRANCH   = 12;      // Each side of a branch
  localparam int    N_TOTAL    = N_FULL + 2 * N_MIXED + 4 * N_BRANCH + 5;
  localparam int    CYC_INSTR  = 24;      // Per delivery with grant delay, response and stalls
  localparam int    CYC_TEST   = 64;      // Reset, idle and drain per test
  localparam int    DRAIN_MAX  = 32;      // Cycles allowed for the tail after fetch stops
  localparam addr_t MIX_BASE   = 32'h80;  // First word of the mixed region

  logic   clk, rst_n, fetch_en_i, branch_i, id_ready_i;
  logic   id_valid_o, id_compressed_o, busy_o;
  logic   instr_req_o, instr_gnt_i, instr_rvalid_i;
  addr_t  branch_addr_i, id_pc_o, instr_addr_o;
  instr_t id_instr_o, instr_rdata_i;

  integer seed;
  int     checks, errors, tests, failed, err_start;
  string  cur_test;
  addr_t  got_pc[$];     // Deliveries seen at decode in order
  instr_t got_instr[$];
  logic   got_c[$];

  fetch_top i_dut (.*);

  instr_mem_model i_mem (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .rdata_o (instr_rdata_i), .rvalid_o (instr_rvalid_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Expected delivery at pc with compressed parcels zero-extended
  function automatic instr_t ref_instr(addr_t pc);
    instr_t     word;
    instr_fmt_e fmt;
    word = i_mem.image[pc[9:2]];
    if (pc[1]) fmt = FMT_C_HIGH;
    else if (word[1:0] != 2'b11) fmt = FMT_C_LOW;
    else fmt = FMT_FULL;
    case (fmt)
      FMT_C_HIGH: return {16'h0, word[31:16]};
      FMT_C_LOW:  return {16'h0, word[15:0]};
      default:    return word;
    endcase
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // Walk the image from start against n recorded deliveries from index first
  task automatic walk_and_check(addr_t start, int first, int n, output int aligned);
    addr_t  pc;
    instr_t exp;
    int     i;
    pc      = start;
    aligned = 0;  // Word-aligned pcs cost one memory request each
    for (i = first; i < first + n; i++) begin
      exp = ref_instr(pc);
      check_value("pc", pc, got_pc[i]);
      check_value("instr", exp, got_instr[i]);
      check_value("compressed", exp[1:0] != 2'b11, got_c[i]);
      if (!pc[1]) aligned++;
      pc = pc + ((exp[1:0] != 2'b11) ? 2 : 4);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Advance one clock and record what decode took in the cycle just ended
  task automatic step_cycle(logic ready);
    @(posedge clk);
    if (instr_req_o) begin
      check_value("instr_addr_o[1:0]", 0, instr_addr_o[1:0]);  // Word requests only
    end
    if (id_valid_o && id_ready_i && !branch_i) begin  // Branch cycle entry is wrong path
      got_pc.push_back(id_pc_o);
      got_instr.push_back(id_instr_o);
      got_c.push_back(id_compressed_o);
    end
    id_ready_i <= ready;
  endtask

  task automatic begin_test(string name);
    cur_test  = name;
    err_start = errors;
    @(posedge clk);
    rst_n      <= 1'b0;
    fetch_en_i <= 1'b0;
    branch_i   <= 1'b0;
    id_ready_i <= 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    got_pc.delete();
    got_instr.delete();
    got_c.delete();
  endtask

  task automatic launch(addr_t start);
    fetch_en_i <= 1'b1;
    if (start != '0) begin
      branch_i      <= 1'b1;  // Redirect away from the reset pc
      branch_addr_i <= start;
    end
    step_cycle(1'b1);
    branch_i <= 1'b0;
  endtask

  // Stop fetching and collect the tail until every granted word is back
  task automatic drain();
    int n;
    fetch_en_i <= 1'b0;
    n = 0;
    do begin
      step_cycle(1'b1);
      n++;
    end while ((instr_req_o || id_valid_o || i_mem.resp_count != i_mem.grant_count)
               && n < DRAIN_MAX);
    check_value("busy_o", 0, busy_o);
    check_value("responses", i_mem.grant_count, i_mem.resp_count);
  endtask

  task automatic finish_test(string name);
    tests++;
    if (errors == err_start) begin
      $display("%-20s passed", name);
    end else begin
      failed++;
      $display("%-20s FAILED", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_test();
    begin_test("idle_after_reset");
    repeat (12) begin
      step_cycle(1'b1);
      check_value("busy_o", 0, busy_o);
      check_value("instr_req_o", 0, instr_req_o);
      check_value("id_valid_o", 0, id_valid_o);
    end
    finish_test("idle_after_reset");
  endtask

  task automatic run_stream(string name, addr_t start, int n, bit stall, bit count_req);
    int aligned;
    begin_test(name);
    launch(start);
    while (got_pc.size() < n) begin
      step_cycle(stall ? (($random(seed) & 3) != 0) : 1'b1);  // Ready low about 1 in 4
    end
    drain();
    walk_and_check(start, 0, got_pc.size(), aligned);
    if (count_req) check_value("requests", aligned, i_mem.grant_count);
    finish_test(name);
  endtask

  task automatic run_branch(string name, addr_t target);
    int split;
    int aligned;
    begin_test(name);
    launch(MIX_BASE);
    while (got_pc.size() < N_BRANCH) step_cycle(1'b1);
    // Branch lands in the cycle where the granted word comes back
    do begin
      step_cycle(1'b1);
    end while (!(instr_req_o && instr_gnt_i));
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    split = got_pc.size();
    step_cycle(1'b1);
    branch_i <= 1'b0;
    while (got_pc.size() < split + N_BRANCH) step_cycle(1'b1);
    drain();
    walk_and_check(MIX_BASE, 0, split, aligned);
    walk_and_check(target, split, got_pc.size() - split, aligned);  // Target comes first
    finish_test(name);
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    id_ready_i    = 1'b1;
    seed          = 62834;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    failed        = 0;
    idle_test();
    run_stream("aligned_stream", '0, N_FULL, 1'b0, 1'b1);
    run_stream("mixed_stream", MIX_BASE, N_MIXED, 1'b0, 1'b1);
    run_stream("decode_stalls", MIX_BASE, N_MIXED, 1'b1, 1'b0);
    run_branch("branch_aligned", 32'h9C);
    run_branch("branch_compressed", 32'h8A);  // High half of a pair
    run_stream("disable_drain", MIX_BASE, 5, 1'b1, 1'b0);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from all deliveries plus per-test overhead
  initial begin
    #((N_TOTAL * CYC_INSTR + 7 * CYC_TEST) * CLK_PERIOD);
    $display("ERROR watchdog expired in %s, decode stopped receiving instructions", cur_test);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/fetch_pkg.sv
design/instr_mem_if.sv
design/fetch_if.sv
design/prefetch_aligned.sv
design/if_id_stage.sv
design/fetch_top.sv
verif/instr_mem_model.sv
verif/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/instr_mem_if.sv
      - design/fetch_if.sv
      - design/prefetch_aligned.sv
      - design/if_id_stage.sv
      - design/fetch_top.sv
  - target: test
    files:
      - verif/instr_mem_model.sv
      - verif/tb_fetch_top.sv
